// File: src/isaPkg.sv
/*
 * ISA definitions for the 16-bit pipelined core: data and register widths,
 * instruction field positions and the opcode encoding
 */
package isaPkg;

	// word size, shared by data, addresses and instructions
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;
	localparam int numRegs = 8;
	localparam int immWidth = 6;
	localparam int opcodeWidth = 4;

	// instruction layout, op | rd | rs | rt, imm overlays rt and the low bits
	localparam int opLsb = 12;
	localparam int rdLsb = 9;
	localparam int rsLsb = 6;
	localparam int rtLsb = 3;

	typedef enum logic [opcodeWidth-1:0] {
		opNop   = 4'h0,
		opAdd   = 4'h1,
		opSub   = 4'h2,
		opAnd   = 4'h3,
		opXor   = 4'h4,
		opAddi  = 4'h5,
		opLoad  = 4'h6,
		opStore = 4'h7,
		opBeqz  = 4'h8,
		opHalt  = 4'h9
	} opcodeT;

	// all-zero word decodes as nop
	localparam logic [dataWidth-1:0] nopInstr = {opNop, {(dataWidth - opcodeWidth){1'b0}}};

endpackage

// File: src/pipePkg.sv
/*
 * Pipeline register bundles passed between stages, the control word that
 * follows each instruction, ALU operations and forwarding selects
 */
package pipePkg;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluXor,
		aluPassB
	} aluOpT;

	typedef enum logic [1:0] {
		fwdNone,
		fwdFromMem,
		fwdFromWb
	} fwdSelT;

	// all zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic isHalt;
		logic isIllegal;
		aluOpT aluOp;
		logic useImm;
	} ctrlT;

	typedef struct packed {
		logic [isaPkg::dataWidth-1:0] instr;
		logic [isaPkg::dataWidth-1:0] pc;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [isaPkg::dataWidth-1:0] pc;
		logic [isaPkg::dataWidth-1:0] rsVal;
		logic [isaPkg::dataWidth-1:0] rtVal;
		logic [isaPkg::dataWidth-1:0] imm;
		logic [isaPkg::regAddrWidth-1:0] rsSel;
		logic [isaPkg::regAddrWidth-1:0] rtSel;
		logic [isaPkg::regAddrWidth-1:0] rdSel;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		logic [isaPkg::dataWidth-1:0] aluOut;
		logic [isaPkg::dataWidth-1:0] storeData;
		logic [isaPkg::regAddrWidth-1:0] rdSel;
	} exMemT;

	typedef struct packed {
		ctrlT ctrl;
		logic [isaPkg::dataWidth-1:0] aluOut;
		logic [isaPkg::dataWidth-1:0] loadData;
		logic [isaPkg::regAddrWidth-1:0] rdSel;
	} memWbT;

endpackage

// File: src/fetchStage.sv
/*
 * Fetch stage: program counter, next-PC selection and the
 * fetch-to-decode register with stall and flush
 */
`timescale 1ns/10ps

module fetchStage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic flush,
	input  logic branchTaken,
	input  logic [isaPkg::dataWidth-1:0] branchTarget,
	input  logic halted,
	input  logic [isaPkg::dataWidth-1:0] instr,
	output logic [isaPkg::dataWidth-1:0] instrAddr,
	output pipePkg::ifIdT ifId
);

	logic [isaPkg::dataWidth-1:0] pc;
	logic [isaPkg::dataWidth-1:0] pcNext;

	// frozen for good once halted
	always_comb begin
		if (halted || stall) begin
			pcNext = pc;
		end else if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pc + isaPkg::dataWidth'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

	assign instrAddr = pc;

	// nops drain the pipe after a squash or a halt
	always_ff @(posedge clk) begin
		if (reset || flush || halted) begin
			ifId.instr <= isaPkg::nopInstr;
			ifId.pc <= '0;
		end else if (!stall) begin
			ifId.instr <= instr;
			ifId.pc <= pc;
		end
	end

endmodule

// File: src/decodeStage.sv
/*
 * Decode stage: field split and control decode, the register file
 * with write-through, and the decode-to-execute register
 */
`timescale 1ns/10ps

module decodeStage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic flush,
	input  pipePkg::ifIdT ifId,
	input  logic wbWrite,
	input  logic [isaPkg::regAddrWidth-1:0] wbSel,
	input  logic [isaPkg::dataWidth-1:0] wbData,
	output logic [isaPkg::regAddrWidth-1:0] rsSel,
	output logic [isaPkg::regAddrWidth-1:0] rtSel,
	output pipePkg::idExT idEx
);

	logic [isaPkg::dataWidth-1:0] regs [isaPkg::numRegs];
	isaPkg::opcodeT opcode;
	logic [isaPkg::regAddrWidth-1:0] rdSel;
	logic [isaPkg::dataWidth-1:0] imm;
	logic [isaPkg::dataWidth-1:0] rsVal;
	logic [isaPkg::dataWidth-1:0] rtVal;
	pipePkg::ctrlT ctrl;

	assign opcode = isaPkg::opcodeT'(ifId.instr[isaPkg::opLsb +: isaPkg::opcodeWidth]);
	assign rdSel = ifId.instr[isaPkg::rdLsb +: isaPkg::regAddrWidth];
	assign rsSel = ifId.instr[isaPkg::rsLsb +: isaPkg::regAddrWidth];
	// a store takes its data register from the rd field, the imm overlays rt
	assign rtSel = (opcode == isaPkg::opStore) ?
		rdSel : ifId.instr[isaPkg::rtLsb +: isaPkg::regAddrWidth];
	assign imm = {{(isaPkg::dataWidth - isaPkg::immWidth){ifId.instr[isaPkg::immWidth-1]}},
		ifId.instr[isaPkg::immWidth-1:0]};

	always_comb begin
		ctrl = '0;
		case (opcode)
			isaPkg::opNop: ;
			isaPkg::opAdd: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = pipePkg::aluAdd;
			end
			isaPkg::opSub: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = pipePkg::aluSub;
			end
			isaPkg::opAnd: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = pipePkg::aluAnd;
			end
			isaPkg::opXor: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = pipePkg::aluXor;
			end
			isaPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
			end
			isaPkg::opLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.useImm = 1'b1;
			end
			isaPkg::opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.useImm = 1'b1;
			end
			// offset rides along as the ALU result
			isaPkg::opBeqz: begin
				ctrl.isBranch = 1'b1;
				ctrl.aluOp = pipePkg::aluPassB;
				ctrl.useImm = 1'b1;
			end
			isaPkg::opHalt: ctrl.isHalt = 1'b1;
			default: ctrl.isIllegal = 1'b1;
		endcase
	end

	// register file, starts at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < isaPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite) begin
			regs[wbSel] <= wbData;
		end
	end

	// same-cycle write-back wins
	assign rsVal = (wbWrite && (wbSel == rsSel)) ? wbData : regs[rsSel];
	assign rtVal = (wbWrite && (wbSel == rtSel)) ? wbData : regs[rtSel];

	always_ff @(posedge clk) begin
		if (reset || stall || flush) begin
			idEx.ctrl <= '0;
		end else begin
			idEx.ctrl <= ctrl;
		end
		idEx.pc <= ifId.pc;
		idEx.rsVal <= rsVal;
		idEx.rtVal <= rtVal;
		idEx.imm <= imm;
		idEx.rsSel <= rsSel;
		idEx.rtSel <= rtSel;
		idEx.rdSel <= rdSel;
	end

endmodule

// File: src/hazardUnit.sv
/*
 * Hazard unit: load-use stall and forwarding selects
 * for both execute operands
 */
`timescale 1ns/10ps

module hazardUnit (
	input  logic [isaPkg::regAddrWidth-1:0] rsSel,
	input  logic [isaPkg::regAddrWidth-1:0] rtSel,
	input  pipePkg::idExT idEx,
	input  pipePkg::exMemT exMem,
	input  pipePkg::memWbT memWb,
	output logic stall,
	output pipePkg::fwdSelT fwdA,
	output pipePkg::fwdSelT fwdB
);

	logic memHitA;
	logic memHitB;
	logic wbHitA;
	logic wbHitB;

	// load in execute, consumer in decode
	assign stall = idEx.ctrl.memRead &&
		((idEx.rdSel == rsSel) || (idEx.rdSel == rtSel));

	assign memHitA = exMem.ctrl.regWrite && (exMem.rdSel == idEx.rsSel);
	assign memHitB = exMem.ctrl.regWrite && (exMem.rdSel == idEx.rtSel);
	assign wbHitA = memWb.ctrl.regWrite && (memWb.rdSel == idEx.rsSel);
	assign wbHitB = memWb.ctrl.regWrite && (memWb.rdSel == idEx.rtSel);

	// youngest producer first
	always_comb begin
		if (memHitA) begin
			fwdA = pipePkg::fwdFromMem;
		end else if (wbHitA) begin
			fwdA = pipePkg::fwdFromWb;
		end else begin
			fwdA = pipePkg::fwdNone;
		end
		if (memHitB) begin
			fwdB = pipePkg::fwdFromMem;
		end else if (wbHitB) begin
			fwdB = pipePkg::fwdFromWb;
		end else begin
			fwdB = pipePkg::fwdNone;
		end
	end

endmodule

// File: src/executeStage.sv
/*
 * Execute stage: forwarding muxes, ALU, branch decision and target,
 * and the execute-to-memory register
 */
`timescale 1ns/10ps

module executeStage (
	input  logic clk,
	input  logic reset,
	input  pipePkg::idExT idEx,
	input  pipePkg::fwdSelT fwdA,
	input  pipePkg::fwdSelT fwdB,
	input  logic [isaPkg::dataWidth-1:0] memFwd,
	input  logic [isaPkg::dataWidth-1:0] wbFwd,
	output logic branchTaken,
	output logic [isaPkg::dataWidth-1:0] branchTarget,
	output logic flush,
	output pipePkg::exMemT exMem
);

	logic [isaPkg::dataWidth-1:0] opA;
	logic [isaPkg::dataWidth-1:0] opB;
	logic [isaPkg::dataWidth-1:0] aluB;
	logic [isaPkg::dataWidth-1:0] aluOut;

	function automatic logic [isaPkg::dataWidth-1:0] pickOperand(
		input pipePkg::fwdSelT sel,
		input logic [isaPkg::dataWidth-1:0] regVal,
		input logic [isaPkg::dataWidth-1:0] memVal,
		input logic [isaPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			pipePkg::fwdFromMem: return memVal;
			pipePkg::fwdFromWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, idEx.rsVal, memFwd, wbFwd);
	assign opB = pickOperand(fwdB, idEx.rtVal, memFwd, wbFwd);
	assign aluB = idEx.ctrl.useImm ? idEx.imm : opB;

	// loads and stores get rs plus imm through the add
	always_comb begin
		case (idEx.ctrl.aluOp)
			pipePkg::aluSub: aluOut = opA - aluB;
			pipePkg::aluAnd: aluOut = opA & aluB;
			pipePkg::aluXor: aluOut = opA ^ aluB;
			pipePkg::aluPassB: aluOut = aluB;
			default: aluOut = opA + aluB;
		endcase
	end

	// word-counted offset from the branch's own pc plus one
	assign branchTaken = idEx.ctrl.isBranch && (opA == '0);
	assign branchTarget = idEx.pc + isaPkg::dataWidth'(1) + idEx.imm;
	assign flush = branchTaken;

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.ctrl <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
		end
		exMem.aluOut <= aluOut;
		exMem.storeData <= opB;
		exMem.rdSel <= idEx.rdSel;
	end

endmodule

// File: src/pipeCore.sv
/*
 * Top level of the five-stage core: stage wiring, memory port,
 * memory-to-writeback register, write-back select, halt and err
 */
`timescale 1ns/10ps

module pipeCore (
	input  logic clk,
	input  logic reset,
	input  logic [isaPkg::dataWidth-1:0] instr,
	output logic [isaPkg::dataWidth-1:0] instrAddr,
	input  logic [isaPkg::dataWidth-1:0] dataReadData,
	output logic [isaPkg::dataWidth-1:0] dataAddr,
	output logic [isaPkg::dataWidth-1:0] dataWriteData,
	output logic dataWrite,
	output logic dataRead,
	output logic halted,
	output logic err
);

	pipePkg::ifIdT ifId;
	pipePkg::idExT idEx;
	pipePkg::exMemT exMem;
	pipePkg::memWbT memWb;

	logic stall;
	logic flush;
	logic branchTaken;
	logic [isaPkg::dataWidth-1:0] branchTarget;
	logic [isaPkg::regAddrWidth-1:0] rsSel;
	logic [isaPkg::regAddrWidth-1:0] rtSel;
	pipePkg::fwdSelT fwdA;
	pipePkg::fwdSelT fwdB;
	logic [isaPkg::dataWidth-1:0] memFwd;
	logic wbWrite;
	logic [isaPkg::dataWidth-1:0] wbData;
	logic retireStop;

	fetchStage fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.halted(halted),
		.instr(instr),
		.instrAddr(instrAddr),
		.ifId(ifId)
	);

	decodeStage decode (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.ifId(ifId),
		.wbWrite(wbWrite),
		.wbSel(memWb.rdSel),
		.wbData(wbData),
		.rsSel(rsSel),
		.rtSel(rtSel),
		.idEx(idEx)
	);

	hazardUnit hazard (
		.rsSel(rsSel),
		.rtSel(rtSel),
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb),
		.stall(stall),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	executeStage execute (
		.clk(clk),
		.reset(reset),
		.idEx(idEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memFwd(memFwd),
		.wbFwd(wbData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.flush(flush),
		.exMem(exMem)
	);

	// ALU result one stage ahead of execute
	assign memFwd = exMem.aluOut;

	// halt or illegal word in write-back
	assign retireStop = memWb.ctrl.isHalt || memWb.ctrl.isIllegal;

	assign dataAddr = exMem.aluOut;
	assign dataWriteData = exMem.storeData;
	assign dataRead = exMem.ctrl.memRead;
	// store right behind a halt is blocked while the halt retires
	assign dataWrite = exMem.ctrl.memWrite && !halted && !retireStop;

	always_ff @(posedge clk) begin
		if (reset) begin
			memWb.ctrl <= '0;
		end else begin
			memWb.ctrl <= exMem.ctrl;
		end
		memWb.aluOut <= exMem.aluOut;
		memWb.loadData <= dataReadData;
		memWb.rdSel <= exMem.rdSel;
	end

	assign wbData = memWb.ctrl.memRead ? memWb.loadData : memWb.aluOut;
	assign wbWrite = memWb.ctrl.regWrite && !halted;

	// sticky until reset
	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
			err <= 1'b0;
		end else if (!halted) begin
			halted <= retireStop;
			err <= memWb.ctrl.isIllegal;
		end
	end

endmodule

// File: verif/pipeCoreChecks_sva.sv
/*
 * Concurrent checks on the data port strobes and the sticky
 * halt and err state, bound into pipeCore
 */
`timescale 1ns/10ps

module pipeCoreChecks (
	input logic clk,
	input logic reset,
	input logic dataWrite,
	input logic dataRead,
	input logic halted,
	input logic err,
	input logic [isaPkg::dataWidth-1:0] instrAddr
);

	// one access per cycle on the data port
	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		!(dataWrite && dataRead))
		else $error("dataWrite and dataRead high in the same cycle");

	noWriteHalted: assert property (@(posedge clk) disable iff (reset)
		halted |-> !dataWrite)
		else $error("dataWrite high while halted");

	// only reset clears these
	haltedSticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else $error("halted fell without reset");

	errSticky: assert property (@(posedge clk) disable iff (reset)
		err |=> err)
		else $error("err fell without reset");

	pcFrozen: assert property (@(posedge clk) disable iff (reset)
		halted |=> $stable(instrAddr))
		else $error("instrAddr moved while halted");

endmodule

bind pipeCore pipeCoreChecks checks (
	.clk(clk),
	.reset(reset),
	.dataWrite(dataWrite),
	.dataRead(dataRead),
	.halted(halted),
	.err(err),
	.instrAddr(instrAddr)
);

// File: verif/pipeCoreTb.sv
/*
 * Testbench for pipeCore: clock, reset, instruction and data memory models,
 * program assembler, ISA reference model and the directed tests
 */
`timescale 1ns/10ps

module pipeCoreTb;

	localparam int memWords = 256;
	localparam int cycleLimit = 2000;

	logic clk;
	logic reset;
	logic [isaPkg::dataWidth-1:0] instr;
	logic [isaPkg::dataWidth-1:0] instrAddr;
	logic [isaPkg::dataWidth-1:0] dataReadData;
	logic [isaPkg::dataWidth-1:0] dataAddr;
	logic [isaPkg::dataWidth-1:0] dataWriteData;
	logic dataWrite;
	logic dataRead;
	logic halted;
	logic err;

	logic [isaPkg::dataWidth-1:0] imem [memWords];
	logic [isaPkg::dataWidth-1:0] dmem [memWords];
	logic [isaPkg::dataWidth-1:0] refMem [memWords];
	logic [isaPkg::dataWidth-1:0] refRegs [isaPkg::numRegs];
	logic refErr;
	int refWrites;
	int refReads;
	int progLen;
	int writeCount;
	int readCount;
	int errorCount;
	int checkCount;
	int cycles = 0;
	integer seed;

	pipeCore dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrAddr(instrAddr),
		.dataReadData(dataReadData),
		.dataAddr(dataAddr),
		.dataWriteData(dataWriteData),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.halted(halted),
		.err(err)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// both memories answer in the same cycle
	assign instr = imem[instrAddr[7:0]];
	assign dataReadData = dmem[dataAddr[7:0]];

	always @(posedge clk) begin
		if (dataWrite === 1'b1) begin
			dmem[dataAddr[7:0]] <= dataWriteData;
			writeCount <= writeCount + 1;
		end
		if (dataRead === 1'b1) begin
			readCount <= readCount + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	function automatic logic [15:0] randomWord();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic clearMemories();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = isaPkg::nopInstr;
			dmem[i] = '0;
		end
		progLen = 0;
	endtask

	task automatic emitWord(input logic [15:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic emitReg(input isaPkg::opcodeT op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [2:0] rt);
		emitWord({op, rd, rs, rt, 3'b000});
	endtask

	task automatic emitImm(input isaPkg::opcodeT op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [5:0] imm);
		emitWord({op, rd, rs, imm});
	endtask

	// sequential ISA model, one instruction per step
	task automatic runReference();
		logic [15:0] word;
		logic [15:0] pc;
		logic [15:0] imm;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] addr;
		logic [2:0] rd;
		logic done;
		int steps;
		pc = '0;
		done = 1'b0;
		steps = 0;
		refErr = 1'b0;
		refWrites = 0;
		refReads = 0;
		for (int i = 0; i < isaPkg::numRegs; i++) begin
			refRegs[i] = '0;
		end
		for (int i = 0; i < memWords; i++) begin
			refMem[i] = dmem[i];
		end
		while (!done && steps < 500) begin
			word = imem[pc[7:0]];
			rd = word[11:9];
			a = refRegs[word[8:6]];
			b = refRegs[word[5:3]];
			imm = {{10{word[5]}}, word[5:0]};
			addr = a + imm;
			pc = pc + 16'd1;
			case (word[15:12])
				isaPkg::opNop: ;
				isaPkg::opAdd: refRegs[rd] = a + b;
				isaPkg::opSub: refRegs[rd] = a - b;
				isaPkg::opAnd: refRegs[rd] = a & b;
				isaPkg::opXor: refRegs[rd] = a ^ b;
				isaPkg::opAddi: refRegs[rd] = addr;
				isaPkg::opLoad: begin
					refRegs[rd] = refMem[addr[7:0]];
					refReads++;
				end
				isaPkg::opStore: begin
					refMem[addr[7:0]] = refRegs[rd];
					refWrites++;
				end
				isaPkg::opBeqz: begin
					if (a == 16'd0) begin
						pc = pc + imm;
					end
				end
				isaPkg::opHalt: done = 1'b1;
				default: begin
					refErr = 1'b1;
					done = 1'b1;
				end
			endcase
			steps++;
		end
		if (!done) begin
			errorCount++;
			$display("reference model never reached a halt or an illegal word");
		end
	endtask

	task automatic pulseReset();
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		writeCount = 0;
		readCount = 0;
	endtask

	// model first, then the DUT, then compare the whole data array
	task automatic runProgram();
		runReference();
		pulseReset();
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		checkValue("err", {15'd0, refErr}, {15'd0, err});
		checkValue("dataWrite count", refWrites[15:0], writeCount[15:0]);
		checkValue("dataRead count", refReads[15:0], readCount[15:0]);
		for (int i = 0; i < memWords; i++) begin
			checkValue($sformatf("dmem[%0d]", i), refMem[i], dmem[i]);
		end
	endtask

	task automatic aluForwarding();
		clearMemories();
		for (int i = 0; i < 3; i++) begin
			dmem[i] = randomWord();
		end
		emitImm(isaPkg::opLoad, 3'd1, 3'd0, 6'd0);
		emitImm(isaPkg::opLoad, 3'd2, 3'd0, 6'd1);
		emitImm(isaPkg::opLoad, 3'd3, 3'd0, 6'd2);
		emitReg(isaPkg::opAdd, 3'd4, 3'd1, 3'd2);
		emitReg(isaPkg::opSub, 3'd5, 3'd4, 3'd3);
		emitReg(isaPkg::opAnd, 3'd6, 3'd5, 3'd4);
		emitReg(isaPkg::opXor, 3'd7, 3'd6, 3'd5);
		emitImm(isaPkg::opAddi, 3'd1, 3'd7, 6'(randomWord()));
		emitReg(isaPkg::opXor, 3'd2, 3'd1, 3'd7);
		for (int r = 1; r < 8; r++) begin
			emitImm(isaPkg::opStore, 3'(r), 3'd0, 6'(8 + r));
		end
		emitImm(isaPkg::opHalt, 3'd0, 3'd0, 6'd0);
		runProgram();
	endtask

	task automatic loadUseStall();
		clearMemories();
		for (int i = 3; i < 6; i++) begin
			dmem[i] = randomWord();
		end
		emitImm(isaPkg::opLoad, 3'd1, 3'd0, 6'd3);
		emitImm(isaPkg::opLoad, 3'd2, 3'd0, 6'd4);
		emitReg(isaPkg::opAdd, 3'd3, 3'd2, 3'd1);
		emitImm(isaPkg::opStore, 3'd3, 3'd0, 6'd16);
		emitImm(isaPkg::opLoad, 3'd4, 3'd0, 6'd5);
		emitImm(isaPkg::opStore, 3'd4, 3'd0, 6'd17);
		emitImm(isaPkg::opLoad, 3'd5, 3'd0, 6'd17);
		emitImm(isaPkg::opAddi, 3'd6, 3'd5, 6'd1);
		emitImm(isaPkg::opStore, 3'd6, 3'd0, 6'd18);
		emitImm(isaPkg::opHalt, 3'd0, 3'd0, 6'd0);
		runProgram();
		checkValue("loaded sum", dmem[3] + dmem[4], dmem[16]);
	endtask

	task automatic branchSquash();
		clearMemories();
		dmem[6] = randomWord() | 16'h0001;
		emitImm(isaPkg::opLoad, 3'd1, 3'd0, 6'd6);
		emitImm(isaPkg::opAddi, 3'd2, 3'd0, 6'd5);
		// r1 is nonzero, falls through
		emitImm(isaPkg::opBeqz, 3'd0, 3'd1, 6'd2);
		emitImm(isaPkg::opStore, 3'd2, 3'd0, 6'd20);
		emitImm(isaPkg::opStore, 3'd2, 3'd0, 6'd21);
		emitReg(isaPkg::opSub, 3'd3, 3'd1, 3'd1);
		emitImm(isaPkg::opBeqz, 3'd0, 3'd3, 6'd2);
		emitImm(isaPkg::opStore, 3'd2, 3'd0, 6'd22);
		emitImm(isaPkg::opStore, 3'd2, 3'd0, 6'd23);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd24);
		emitImm(isaPkg::opBeqz, 3'd0, 3'd0, 6'd3);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd25);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd26);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd27);
		emitImm(isaPkg::opHalt, 3'd0, 3'd0, 6'd0);
		runProgram();
	endtask

	task automatic haltFreeze();
		logic [15:0] heldAddr;
		clearMemories();
		emitImm(isaPkg::opAddi, 3'd1, 3'd0, 6'd9);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd30);
		emitImm(isaPkg::opHalt, 3'd0, 3'd0, 6'd0);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd31);
		emitImm(isaPkg::opStore, 3'd1, 3'd0, 6'd29);
		runProgram();
		checkValue("err", 16'd0, {15'd0, err});
		heldAddr = instrAddr;
		repeat (20) begin
			@(negedge clk);
			checkValue("instrAddr", heldAddr, instrAddr);
			checkValue("halted", 16'd1, {15'd0, halted});
		end
	endtask

	task automatic illegalOpcode();
		clearMemories();
		emitImm(isaPkg::opAddi, 3'd3, 3'd0, 6'd7);
		emitImm(isaPkg::opStore, 3'd3, 3'd0, 6'd28);
		// opcode 0xc names r3 as destination
		emitWord({4'hc, 3'd3, 3'd0, 6'd5});
		emitImm(isaPkg::opStore, 3'd3, 3'd0, 6'd27);
		emitImm(isaPkg::opHalt, 3'd0, 3'd0, 6'd0);
		runProgram();
		checkValue("err", 16'd1, {15'd0, err});
		checkValue("r3", refRegs[3], dut.decode.regs[3]);
	endtask

	initial begin
		seed = 32'h71f2_e693;
		reset = 1'b1;
		errorCount = 0;
		checkCount = 0;
		writeCount = 0;
		readCount = 0;
		clearMemories();
		aluForwarding();
		loadUseStall();
		branchSquash();
		haltFreeze();
		illegalOpcode();
		$display("errors: %0d, checks: %0d", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: pipeCore.f
src/isaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/pipeCore.sv
verif/pipeCoreChecks_sva.sv
verif/pipeCoreTb.sv

// File: Bender.yml
package:
  name: pipeCore

sources:
  - src/isaPkg.sv
  - src/pipePkg.sv
  - src/fetchStage.sv
  - src/decodeStage.sv
  - src/hazardUnit.sv
  - src/executeStage.sv
  - src/pipeCore.sv
  - target: test
    files:
      - verif/pipeCoreChecks_sva.sv
      - verif/pipeCoreTb.sv
